//--- tracePkg.sv
package tracePkg;

    localparam int traceNum = 3;
    localparam int tagWidth = 8;
    localparam int endDataWidth = 64;

    // Default sampler widths.
    localparam int ch0WidthDef = 28;
    localparam int ch1WidthDef = 67;
    localparam int ch2WidthDef = 13;

    // Tag byte written below each payload.
    typedef enum logic [tagWidth-1:0] {
        tagCh0 = 0,
        tagCh1 = 1,
        tagCh2 = 2,
        tagEnd = 128
    } traceTag;

    function automatic int alignUp(input int n, input int unit);
        return ((n + unit - 1) / unit) * unit;
    endfunction

    // Data padded to bytes, plus the tag byte.
    function automatic int packWidth(input int dataWidth);
        return alignUp(dataWidth, 8) + tagWidth;
    endfunction

    function automatic int recordWidth(input int w0, input int w1, input int w2, input int beat);
        return alignUp(packWidth(w0) + packWidth(w1) + packWidth(w2) + tagWidth + endDataWidth,
                       beat);
    endfunction

    // Must hold the full record size in bytes.
    function automatic int lenWidth(input int recBits);
        return $clog2(recBits / 8 + 1);
    endfunction

endpackage

//--- streamPkg.sv
package streamPkg;

    // Downstream bus word.
    localparam int beatWidth = 64;

    // Serializer states.
    typedef enum logic {
        serIdle,
        serSend
    } serState;

endpackage

//--- batchIf.sv
`timescale 1ns/1ps

interface batchIf import tracePkg::*; #(
    parameter int recordBits = 256
) ();

    logic                              recValid;
    logic                              recReady;
    logic [recordBits-1:0]             recData;
    logic [lenWidth(recordBits)-1:0]   recLen;    // Record size in bytes.

    modport producer (
        output recValid,
        output recData,
        output recLen,
        input  recReady
    );

    modport consumer (
        input  recValid,
        input  recData,
        input  recLen,
        output recReady
    );

endinterface

//--- traceBatch.sv
`timescale 1ns/1ps

module traceBatch import tracePkg::*; #(
    parameter int ch0Width = ch0WidthDef,
    parameter int ch1Width = ch1WidthDef,
    parameter int ch2Width = ch2WidthDef
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ch0Valid,
    input  logic                ch1Valid,
    input  logic                ch2Valid,
    input  logic                ch0Enable,
    input  logic                ch1Enable,
    input  logic                ch2Enable,
    input  logic [ch0Width-1:0] ch0Data,
    input  logic [ch1Width-1:0] ch1Data,
    input  logic [ch2Width-1:0] ch2Data,
    output logic                ch0Ready,
    output logic                ch1Ready,
    output logic                ch2Ready,
    batchIf.producer            rec
);

    localparam int recordBits = $bits(rec.recData);
    localparam int lenBits = lenWidth(recordBits);

    localparam logic [lenBits-1:0] ch0Bytes = lenBits'(packWidth(ch0Width) / 8);
    localparam logic [lenBits-1:0] ch1Bytes = lenBits'(packWidth(ch1Width) / 8);
    localparam logic [lenBits-1:0] ch2Bytes = lenBits'(packWidth(ch2Width) / 8);
    localparam logic [lenBits-1:0] endBytes = lenBits'((tagWidth + endDataWidth) / 8);
    localparam logic [tagWidth+endDataWidth-1:0] endField = {{endDataWidth{1'b0}}, tagEnd};

    logic [traceNum:0]      full;       // Capture register, then the compress stages.
    logic [traceNum:0]      readyIn;
    logic                   anyValid;
    logic                   anyEnable;

    logic [ch0Width-1:0]    capData0;
    logic [ch1Width-1:0]    capData1;
    logic [ch2Width-1:0]    capData2;
    logic [traceNum-1:0]    capEn;

    logic [recordBits-1:0]  rec1;
    logic [lenBits-1:0]     len1;
    logic [ch1Width-1:0]    s1Data1;
    logic [ch2Width-1:0]    s1Data2;
    logic                   s1En1;
    logic                   s1En2;

    logic [recordBits-1:0]  rec2;
    logic [lenBits-1:0]     len2;
    logic [ch2Width-1:0]    s2Data2;
    logic                   s2En2;

    logic [recordBits-1:0]  rec3;
    logic [lenBits-1:0]     len3;
    logic [recordBits-1:0]  ch2Field;
    logic [lenBits-1:0]     endOffset;

    assign anyValid = ch0Valid | ch1Valid | ch2Valid;
    assign anyEnable = ch0Enable | ch1Enable | ch2Enable;

    // A stage can take new data if empty or if its content moves on.
    assign readyIn[traceNum] = !full[traceNum] || rec.recReady;
    for (genvar i = 0; i < traceNum; i++) begin : readyChain
        assign readyIn[i] = !full[i] || readyIn[i+1];
    end

    assign ch0Ready = readyIn[0];
    assign ch1Ready = readyIn[0];
    assign ch2Ready = readyIn[0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= '0;
        end else begin
            if (readyIn[0]) begin
                full[0] <= anyValid && anyEnable;   // Nothing enabled, nothing kept.
            end
            for (int i = 1; i <= traceNum; i++) begin
                if (readyIn[i]) begin
                    full[i] <= full[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readyIn[0] && anyValid) begin
            capData0 <= ch0Data;
            capData1 <= ch1Data;
            capData2 <= ch2Data;
            capEn <= {ch2Enable, ch1Enable, ch0Enable};
        end
    end

    // Channel 0 always lands at offset zero.
    always_ff @(posedge clk) begin
        if (readyIn[1] && full[0]) begin
            rec1 <= capEn[0] ? recordBits'({capData0, tagCh0}) : '0;
            len1 <= capEn[0] ? ch0Bytes : '0;
            s1Data1 <= capData1;
            s1Data2 <= capData2;
            s1En1 <= capEn[1];
            s1En2 <= capEn[2];
        end
    end

    always_ff @(posedge clk) begin
        if (readyIn[2] && full[1]) begin
            if (s1En1) begin
                rec2 <= rec1 | (recordBits'({s1Data1, tagCh1}) << {len1, 3'b000});
                len2 <= len1 + ch1Bytes;
            end else begin
                rec2 <= rec1;
                len2 <= len1;
            end
            s2Data2 <= s1Data2;
            s2En2 <= s1En2;
        end
    end

    // Last stage also closes the record with the end tag and end word.
    assign ch2Field = s2En2 ? (recordBits'({s2Data2, tagCh2}) << {len2, 3'b000}) : '0;
    assign endOffset = s2En2 ? len2 + ch2Bytes : len2;

    always_ff @(posedge clk) begin
        if (readyIn[3] && full[2]) begin
            rec3 <= rec2 | ch2Field | (recordBits'(endField) << {endOffset, 3'b000});
            len3 <= endOffset + endBytes;
        end
    end

    assign rec.recValid = full[traceNum];
    assign rec.recData = rec3;
    assign rec.recLen = len3;

    recLenRange: assert property (@(posedge clk) disable iff (!rst)
        rec.recValid |-> (rec.recLen >= endBytes && rec.recLen <= lenBits'(recordBits / 8)));

endmodule

//--- batchSerializer.sv
`timescale 1ns/1ps

module batchSerializer import tracePkg::*; import streamPkg::*; #(
    parameter int recordBits = recordWidth(ch0WidthDef, ch1WidthDef, ch2WidthDef, beatWidth)
) (
    input  logic                 clk,
    input  logic                 rst,
    batchIf.consumer             rec,
    output logic                 beatValid,
    output logic [beatWidth-1:0] beatData,
    output logic                 beatLast,
    input  logic                 beatReady
);

    localparam int lenBits = lenWidth(recordBits);
    localparam int beatBytes = beatWidth / 8;

    serState               state;
    logic [recordBits-1:0] holdData;   // Current beat sits in the low bits.
    logic [lenBits-1:0]    beatsLeft;
    logic                  beatFire;

    assign rec.recReady = (state == serIdle);
    assign beatValid = (state == serSend);
    assign beatData = holdData[beatWidth-1:0];
    assign beatLast = beatValid && (beatsLeft == lenBits'(1));
    assign beatFire = beatValid && beatReady;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= serIdle;
            beatsLeft <= '0;
        end else begin
            case (state)
                serIdle: begin
                    if (rec.recValid) begin
                        state <= serSend;
                        beatsLeft <= lenBits'((rec.recLen + beatBytes - 1) / beatBytes);
                    end
                end
                serSend: begin
                    if (beatFire) begin
                        beatsLeft <= beatsLeft - 1'b1;
                        if (beatLast) begin
                            state <= serIdle;
                        end
                    end
                end
                default: state <= serIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rec.recValid && rec.recReady) begin
            holdData <= rec.recData;
        end else if (beatFire) begin
            holdData <= holdData >> beatWidth;  // Next beat moves down.
        end
    end

    beatHold: assert property (@(posedge clk) disable iff (!rst)
        beatValid && !beatReady |=> beatValid && $stable(beatData) && $stable(beatLast));

endmodule

//--- traceCapture.sv
`timescale 1ns/1ps

module traceCapture import tracePkg::*; import streamPkg::*; #(
    parameter int ch0Width = ch0WidthDef,
    parameter int ch1Width = ch1WidthDef,
    parameter int ch2Width = ch2WidthDef
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ch0Valid,
    input  logic                 ch1Valid,
    input  logic                 ch2Valid,
    input  logic                 ch0Enable,
    input  logic                 ch1Enable,
    input  logic                 ch2Enable,
    input  logic [ch0Width-1:0]  ch0Data,
    input  logic [ch1Width-1:0]  ch1Data,
    input  logic [ch2Width-1:0]  ch2Data,
    output logic                 ch0Ready,
    output logic                 ch1Ready,
    output logic                 ch2Ready,
    output logic                 beatValid,
    output logic [beatWidth-1:0] beatData,
    output logic                 beatLast,
    input  logic                 beatReady
);

    // Record size rounded up to whole beats.
    localparam int recordBits = recordWidth(ch0Width, ch1Width, ch2Width, beatWidth);

    batchIf #(.recordBits(recordBits)) recBus ();

    traceBatch #(
        .ch0Width(ch0Width),
        .ch1Width(ch1Width),
        .ch2Width(ch2Width)
    ) batchInst (
        .clk(clk),
        .rst(rst),
        .ch0Valid(ch0Valid),
        .ch1Valid(ch1Valid),
        .ch2Valid(ch2Valid),
        .ch0Enable(ch0Enable),
        .ch1Enable(ch1Enable),
        .ch2Enable(ch2Enable),
        .ch0Data(ch0Data),
        .ch1Data(ch1Data),
        .ch2Data(ch2Data),
        .ch0Ready(ch0Ready),
        .ch1Ready(ch1Ready),
        .ch2Ready(ch2Ready),
        .rec(recBus.producer)
    );

    batchSerializer #(.recordBits(recordBits)) serInst (
        .clk(clk),
        .rst(rst),
        .rec(recBus.consumer),
        .beatValid(beatValid),
        .beatData(beatData),
        .beatLast(beatLast),
        .beatReady(beatReady)
    );

endmodule

//--- tbTraceCapture.sv
`timescale 1ns/1ps

module tbTraceCapture import tracePkg::*; import streamPkg::*; ();

    localparam int w0 = ch0WidthDef;
    localparam int w1 = ch1WidthDef;
    localparam int w2 = ch2WidthDef;
    localparam int b0 = (w0 + 7) / 8 + 1;   // Padded data plus tag byte.
    localparam int b1 = (w1 + 7) / 8 + 1;
    localparam int b2 = (w2 + 7) / 8 + 1;
    localparam int maxBytes = b0 + b1 + b2 + 9;
    localparam int recBits = ((maxBytes + 7) / 8) * beatWidth;
    localparam int totalSamples = 89;

    logic clk = 1'b0;
    logic rst, beatReady, beatValid, beatLast;
    logic ch0Valid, ch1Valid, ch2Valid, ch0Enable, ch1Enable, ch2Enable;
    logic ch0Ready, ch1Ready, ch2Ready;
    logic [w0-1:0] ch0Data;
    logic [w1-1:0] ch1Data;
    logic [w2-1:0] ch2Data;
    logic [beatWidth-1:0] beatData;

    // Expected beats in order, with the capture time of each record.
    logic [beatWidth-1:0] expBeats[$];
    logic expLasts[$];
    int capCycles[$];
    bit isolatedQ[$];
    logic [beatWidth-1:0] frontData;
    logic frontLast, frontValid;

    logic [recBits-1:0] gotRec, lastRecord;
    integer seed = 12;
    int cycle, beatIdx, lastBeats, lat, errCount, testsPassed, testsFailed, errBefore;
    int beatsOut, recordsIn, recordsOut, beatsBefore;
    bit atFirst, latDone, stallMode, sawBackPressure;

    traceCapture UUT (
        .clk(clk), .rst(rst),
        .ch0Valid(ch0Valid), .ch1Valid(ch1Valid), .ch2Valid(ch2Valid),
        .ch0Enable(ch0Enable), .ch1Enable(ch1Enable), .ch2Enable(ch2Enable),
        .ch0Data(ch0Data), .ch1Data(ch1Data), .ch2Data(ch2Data),
        .ch0Ready(ch0Ready), .ch1Ready(ch1Ready), .ch2Ready(ch2Ready),
        .beatValid(beatValid), .beatData(beatData), .beatLast(beatLast),
        .beatReady(beatReady)
    );

    always #10 clk = ~clk;

    // Kept channels from byte 0 up, then the end tag and eight zero bytes.
    function automatic void buildBeats(input logic [w0-1:0] d0, input logic [w1-1:0] d1,
                                       input logic [w2-1:0] d2, input logic [2:0] en);
        logic [recBits-1:0] rec;
        int off;
        int nBeats;
        rec = '0;
        off = 0;
        if (en[0]) begin
            rec = rec | (recBits'({d0, 8'h00}) << (8 * off));
            off = off + b0;
        end
        if (en[1]) begin
            rec = rec | (recBits'({d1, 8'h01}) << (8 * off));
            off = off + b1;
        end
        if (en[2]) begin
            rec = rec | (recBits'({d2, 8'h02}) << (8 * off));
            off = off + b2;
        end
        rec = rec | (recBits'(8'h80) << (8 * off));
        off = off + 9;
        nBeats = (off + 7) / 8;
        for (int k = 0; k < nBeats; k++) begin
            expBeats.push_back(rec[64*k +: 64]);
            expLasts.push_back(k == nBeats - 1);
        end
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            expBeats.delete();
            expLasts.delete();
            capCycles.delete();
            isolatedQ.delete();
            atFirst = 1'b1;
            latDone = 1'b0;
            beatIdx = 0;
            gotRec = '0;
            frontValid <= 1'b0;
            frontData <= '0;
            frontLast <= 1'b0;
        end else begin
            if (beatValid && atFirst && !latDone && capCycles.size() != 0) begin
                lat = cycle - capCycles[0];
                if (isolatedQ[0]) begin
                    assert (lat == 5) else begin
                        $display("ERR latency exp %h got %h", 5, lat);
                        errCount++;
                    end
                end else begin
                    assert (lat >= 5) else begin
                        $display("ERR latency exp >= %h got %h", 5, lat);
                        errCount++;
                    end
                end
                latDone = 1'b1;
            end
            if (beatValid && beatReady) begin
                if (beatIdx < recBits / beatWidth) gotRec[beatIdx*64 +: 64] = beatData;
                beatIdx++;
                beatsOut++;
                if (expBeats.size() != 0) begin
                    void'(expBeats.pop_front());
                    void'(expLasts.pop_front());
                end
                if (beatLast) begin
                    lastRecord = gotRec;
                    lastBeats = beatIdx;
                    gotRec = '0;
                    beatIdx = 0;
                    atFirst = 1'b1;
                    latDone = 1'b0;
                    recordsOut++;
                    if (capCycles.size() != 0) begin
                        void'(capCycles.pop_front());
                        void'(isolatedQ.pop_front());
                    end
                end else begin
                    atFirst = 1'b0;
                end
            end
            if ((ch0Valid || ch1Valid || ch2Valid) && ch0Ready &&
                    (ch0Enable || ch1Enable || ch2Enable)) begin
                isolatedQ.push_back(expBeats.size() == 0 && !stallMode);
                capCycles.push_back(cycle);
                buildBeats(ch0Data, ch1Data, ch2Data, {ch2Enable, ch1Enable, ch0Enable});
                recordsIn++;
            end
            if (!ch0Ready) sawBackPressure = 1'b1;
            frontValid <= expBeats.size() != 0;
            frontData <= (expBeats.size() != 0) ? expBeats[0] : '0;
            frontLast <= (expLasts.size() != 0) ? expLasts[0] : 1'b0;
        end
        cycle++;
    end

    beatExpected: assert property (@(posedge clk) disable iff (!rst)
        beatValid && beatReady |-> frontValid)
        else begin
            $display("beat accepted while no record was expected");
            errCount++;
        end

    beatDataCheck: assert property (@(posedge clk) disable iff (!rst)
        beatValid && beatReady && frontValid |-> beatData == frontData)
        else begin
            $display("ERR beatData exp %h got %h", $sampled(frontData), $sampled(beatData));
            errCount++;
        end

    beatLastCheck: assert property (@(posedge clk) disable iff (!rst)
        beatValid && beatReady && frontValid |-> beatLast == frontLast)
        else begin
            $display("ERR beatLast exp %h got %h", $sampled(frontLast), $sampled(beatLast));
            errCount++;
        end

    beatStable: assert property (@(posedge clk) disable iff (!rst)
        beatValid && !beatReady |=> beatValid && $stable(beatData) && $stable(beatLast))
        else begin
            $display("beat changed or dropped while the bus was stalled");
            errCount++;
        end

    // All three sampler readies are one shared value.
    readyShared: assert property (@(posedge clk) disable iff (!rst)
        ch1Ready == ch0Ready && ch2Ready == ch0Ready)
        else begin
            $display("ERR chReady exp %h got %h", {3{$sampled(ch0Ready)}},
                     {$sampled(ch2Ready), $sampled(ch1Ready), $sampled(ch0Ready)});
            errCount++;
        end

    task automatic tick();
        @(posedge clk);
        if (stallMode) beatReady <= 1'($random(seed));
    endtask

    // Holds the sample until the ready seen at an edge takes it.
    task automatic sendSample(input logic [2:0] en);
        logic [2:0] vmask;
        vmask = 3'({$random(seed)} % 7 + 1);
        ch0Valid <= vmask[0];
        ch1Valid <= vmask[1];
        ch2Valid <= vmask[2];
        ch0Enable <= en[0];
        ch1Enable <= en[1];
        ch2Enable <= en[2];
        ch0Data <= w0'($random(seed));
        ch1Data <= w1'({$random(seed), $random(seed), $random(seed)});
        ch2Data <= w2'($random(seed));
        do tick(); while (!ch0Ready);
    endtask

    task automatic setIdle();
        ch0Valid <= 1'b0;
        ch1Valid <= 1'b0;
        ch2Valid <= 1'b0;
    endtask

    task automatic waitDrain();
        int guard;
        guard = 0;
        tick();
        while (frontValid && guard < 400) begin
            tick();
            guard++;
        end
        if (guard >= 400) begin
            $display("records still pending after 400 cycles");
            errCount++;
        end
    endtask

    task automatic report(input string name);
        if (errCount == errBefore) begin
            $display("%s: ok", name);
            testsPassed++;
        end else begin
            $display("%s: %0d errors", name, errCount - errBefore);
            testsFailed++;
        end
        errBefore = errCount;
    endtask

    initial begin
        rst = 1'b0;
        beatReady = 1'b1;
        {ch0Valid, ch1Valid, ch2Valid, ch0Enable, ch1Enable, ch2Enable} = '0;
        ch0Data = '0;
        ch1Data = '0;
        ch2Data = '0;
        repeat (16) tick();
        rst <= 1'b1;
        tick();
        assert (!beatValid) else begin
            $display("ERR beatValid exp %h got %h", 1'b0, beatValid);
            errCount++;
        end
        assert (!beatLast) else begin
            $display("ERR beatLast exp %h got %h", 1'b0, beatLast);
            errCount++;
        end
        assert ({ch2Ready, ch1Ready, ch0Ready} == 3'b111) else begin
            $display("ERR chReady exp %h got %h", 3'b111, {ch2Ready, ch1Ready, ch0Ready});
            errCount++;
        end
        report("reset state");

        for (int en = 1; en < 8; en++) begin
            sendSample(3'(en));
            setIdle();
            waitDrain();
        end
        beatsBefore = beatsOut;
        sendSample(3'b000);   // Nothing enabled, so no record.
        setIdle();
        repeat (8) tick();
        assert (beatsOut == beatsBefore) else begin
            $display("ERR beatsOut exp %h got %h", beatsBefore, beatsOut);
            errCount++;
        end
        report("single captures");

        sendSample(3'b111);
        setIdle();
        waitDrain();
        assert (lastBeats == 4) else begin
            $display("ERR beatCount exp %h got %h", 4, lastBeats);
            errCount++;
        end
        assert (lastRecord[18*8 +: 8] == 8'h80) else begin
            $display("ERR endTag exp %h got %h", 8'h80, lastRecord[18*8 +: 8]);
            errCount++;
        end
        assert ((lastRecord >> (19 * 8)) == '0) else begin
            $display("ERR recordTail exp %h got %h", 0, lastRecord >> (19 * 8));
            errCount++;
        end
        report("max record");

        for (int i = 0; i < 40; i++) sendSample(3'($random(seed)));
        setIdle();
        waitDrain();
        assert (recordsOut == recordsIn) else begin
            $display("ERR recordsOut exp %h got %h", recordsIn, recordsOut);
            errCount++;
        end
        report("back-to-back");

        stallMode = 1'b1;
        sawBackPressure = 1'b0;
        for (int i = 0; i < 40; i++) sendSample(3'($random(seed)));
        setIdle();
        waitDrain();
        stallMode = 1'b0;
        beatReady <= 1'b1;
        assert (sawBackPressure) else begin
            $display("sampler ready never dropped under stalls");
            errCount++;
        end
        assert (recordsOut == recordsIn) else begin
            $display("ERR recordsOut exp %h got %h", recordsIn, recordsOut);
            errCount++;
        end
        report("random stalls");

        $display("tests passed %0d failed %0d", testsPassed, testsFailed);
        if (errCount == 0 && testsFailed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (totalSamples * 40 + 200) @(posedge clk);
        $display("run timed out before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- traceCapture.f
tracePkg.sv
streamPkg.sv
batchIf.sv
traceBatch.sv
batchSerializer.sv
traceCapture.sv
tbTraceCapture.sv

//--- runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f traceCapture.f \
    --top-module tbTraceCapture \
    -o simTrace

./obj_dir/simTrace > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported errors"
    exit 1
fi
